/* verilog/rv32_isa_pkg.sv */
package rv32_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, instr[6:0].
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Shared by OP and OP_IMM.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by funct7.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LW_SW = 3'b010;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA.

endpackage

/* verilog/core_pkg.sv */
package core_pkg;

    import rv32_isa_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_ACCESS,
        ST_WRITEBACK
    } stage_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    typedef enum logic {
        RS1,
        PC
    } op_a_sel_e;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        logic      op_b_imm;
        logic      is_branch;
        logic      is_jump;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
        logic [2:0] funct3;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } bus_req_t;

endpackage

/* verilog/rv32_decoder.sv */
`timescale 1ns/1ns

module rv32_decoder
    import rv32_isa_pkg::*, core_pkg::*;
(
    input  word_t    i_instr,
    output decoded_t o_dec
);

    logic [6:0] opcode;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_e f_alu_op(input logic [2:0] f3, input logic sub,
                                         input logic sra);
        case (f3)
            F3_ADD:  return sub ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return sra ? SRA : SRL;
            F3_OR:   return OR;
            default: return AND;
        endcase
    endfunction

    assign opcode = i_instr[6:0];
    assign alt    = (i_instr[31:25] == F7_ALT);

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        o_dec = '0; // Unknown opcodes stay a no-op.
        o_dec.rs1 = i_instr[19:15];
        o_dec.rs2 = i_instr[24:20];
        o_dec.rd = i_instr[11:7];
        o_dec.funct3 = i_instr[14:12];
        o_dec.op_b_imm = 1'b1;
        case (opcode)
            OPC_LUI: begin
                o_dec.imm = imm_u;
                o_dec.alu_op = PASS_B;
                o_dec.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                o_dec.imm = imm_u;
                o_dec.op_a_sel = PC;
                o_dec.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                o_dec.imm = imm_j;
                o_dec.op_a_sel = PC;
                o_dec.is_jump = 1'b1;
                o_dec.writes_rd = 1'b1;
            end
            OPC_JALR: begin
                o_dec.imm = imm_i;
                o_dec.is_jump = 1'b1;
                o_dec.writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                o_dec.imm = imm_b; // ALU gives the target, compare runs on rs1/rs2.
                o_dec.op_a_sel = PC;
                o_dec.is_branch = 1'b1;
            end
            OPC_OP_IMM: begin
                o_dec.imm = imm_i;
                o_dec.alu_op = f_alu_op(i_instr[14:12], 1'b0, alt);
                o_dec.writes_rd = 1'b1;
            end
            OPC_OP: begin
                o_dec.alu_op = f_alu_op(i_instr[14:12], alt, alt);
                o_dec.op_b_imm = 1'b0;
                o_dec.writes_rd = 1'b1;
            end
            OPC_LOAD: begin
                o_dec.imm = imm_i;
                o_dec.is_load = (i_instr[14:12] == F3_LW_SW);
                o_dec.writes_rd = (i_instr[14:12] == F3_LW_SW);
            end
            OPC_STORE: begin
                o_dec.imm = imm_s;
                o_dec.is_store = (i_instr[14:12] == F3_LW_SW);
            end
            default: begin
                o_dec.op_b_imm = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/rv32_regfile.sv */
`timescale 1ns/1ns

module rv32_regfile
    import rv32_isa_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    output word_t    o_rs1_val,
    output word_t    o_rs2_val,
    input  logic     i_we,
    input  reg_idx_t i_rd,
    input  word_t    i_wdata
);

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin // x0 is never written.
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_val = regs[i_rs1];
    assign o_rs2_val = regs[i_rs2];

    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_rs1 == '0 |-> o_rs1_val == '0) and (i_rs2 == '0 |-> o_rs2_val == '0));

endmodule

/* verilog/rv32_alu.sv */
`timescale 1ns/1ns

module rv32_alu
    import rv32_isa_pkg::*, core_pkg::*;
(
    input  decoded_t i_dec,
    input  word_t    i_rs1_val,
    input  word_t    i_rs2_val,
    input  word_t    i_pc,
    output word_t    o_result,
    output logic     o_branch_taken
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign op_a  = (i_dec.op_a_sel == PC) ? i_pc : i_rs1_val;
    assign op_b  = i_dec.op_b_imm ? i_dec.imm : i_rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_dec.alu_op)
            SUB:     o_result = op_a - op_b;
            SLL:     o_result = op_a << shamt;
            SLT:     o_result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    o_result = {31'b0, op_a < op_b};
            XOR:     o_result = op_a ^ op_b;
            SRL:     o_result = op_a >> shamt;
            SRA:     o_result = $signed(op_a) >>> shamt;
            OR:      o_result = op_a | op_b;
            AND:     o_result = op_a & op_b;
            PASS_B:  o_result = op_b;
            default: o_result = op_a + op_b; // Also targets and addresses.
        endcase
    end

    // Branch compares always use the registers.
    assign eq  = (i_rs1_val == i_rs2_val);
    assign lt  = ($signed(i_rs1_val) < $signed(i_rs2_val));
    assign ltu = (i_rs1_val < i_rs2_val);

    always_comb begin
        case (i_dec.funct3)
            F3_BEQ:  o_branch_taken = eq;
            F3_BNE:  o_branch_taken = !eq;
            F3_BLT:  o_branch_taken = lt;
            F3_BGE:  o_branch_taken = !lt;
            F3_BLTU: o_branch_taken = ltu;
            F3_BGEU: o_branch_taken = !ltu;
            default: o_branch_taken = 1'b0;
        endcase
        o_branch_taken = o_branch_taken & i_dec.is_branch;
    end

endmodule

/* verilog/wb_master.sv */
`timescale 1ns/1ns

module wb_master
    import rv32_isa_pkg::*, core_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_req_valid,
    input  bus_req_t i_req,
    output logic     o_idle,
    output logic     o_done,
    output word_t    o_rdata,
    output logic     o_cyc,
    output logic     o_stb,
    output logic     o_we,
    output word_t    o_addr,
    output word_t    o_data,
    input  logic     i_ack,
    input  logic     i_stall,
    input  word_t    i_data
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_STROBE,
        WB_WAIT
    } wb_state_e;

    wb_state_e state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= WB_IDLE;
            o_cyc <= 1'b0;
            o_stb <= 1'b0;
            o_we <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                WB_IDLE: if (i_req_valid) begin
                    o_cyc <= 1'b1;
                    o_stb <= 1'b1;
                    o_we <= i_req.we;
                    state <= WB_STROBE;
                end
                WB_STROBE: if (!i_stall) begin // Slave took the strobe.
                    o_stb <= 1'b0;
                    state <= WB_WAIT;
                end
                WB_WAIT: if (i_ack) begin
                    o_cyc <= 1'b0;
                    o_we <= 1'b0;
                    o_done <= 1'b1;
                    state <= WB_IDLE;
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == WB_IDLE && i_req_valid) begin
            o_addr <= i_req.addr;
            o_data <= i_req.wdata;
        end
        if (state == WB_WAIT && i_ack) begin
            o_rdata <= i_data;
        end
    end

    assign o_idle = (state == WB_IDLE);

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) o_stb |-> o_cyc);
    a_req_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_req_valid |-> state == WB_IDLE);

endmodule

/* verilog/rv32_control.sv */
`timescale 1ns/1ns

module rv32_control
    import rv32_isa_pkg::*, core_pkg::*;
#(
    parameter word_t P_RESET_PC = 32'h0000_0000
) (
    input  logic     i_clk,
    input  logic     i_rst,
    output word_t    o_instr,
    input  decoded_t i_dec,
    input  word_t    i_alu_result,
    input  logic     i_branch_taken,
    input  word_t    i_rs2_val,
    output word_t    o_pc,
    output logic     o_req_valid,
    output bus_req_t o_req,
    input  logic     i_bus_idle,
    input  logic     i_bus_done,
    input  word_t    i_bus_rdata,
    output logic     o_rd_we,
    output reg_idx_t o_rd,
    output word_t    o_rd_wdata
);

    stage_e   stage;
    word_t    pc;
    word_t    pc_plus4;
    word_t    next_pc;
    decoded_t dec_q;
    word_t    alu_q;
    logic     taken_q;
    logic     bus_wait;
    logic     mem_op;

    assign pc_plus4 = pc + 32'd4;
    assign mem_op = dec_q.is_load | dec_q.is_store;
    assign next_pc = (dec_q.is_jump || taken_q) ? {alu_q[31:1], 1'b0} : pc_plus4;

    // One request per fetch or memory access.
    assign o_req_valid = (stage == ST_FETCH || (stage == ST_ACCESS && mem_op))
                         && i_bus_idle && !bus_wait;

    always_comb begin
        o_req.addr = (stage == ST_FETCH) ? pc : alu_q;
        o_req.wdata = i_rs2_val;
        o_req.we = (stage == ST_ACCESS) && dec_q.is_store;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage <= ST_FETCH;
            pc <= P_RESET_PC;
            bus_wait <= 1'b0;
        end else begin
            if (o_req_valid) begin
                bus_wait <= 1'b1;
            end else if (i_bus_done) begin
                bus_wait <= 1'b0;
            end
            case (stage)
                ST_FETCH:     if (i_bus_done) stage <= ST_DECODE;
                ST_DECODE:    stage <= ST_EXECUTE;
                ST_EXECUTE:   stage <= ST_ACCESS;
                ST_ACCESS:    if (!mem_op || i_bus_done) stage <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    pc <= next_pc;
                    stage <= ST_FETCH;
                end
                default:      stage <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == ST_FETCH && i_bus_done) o_instr <= i_bus_rdata;
        if (stage == ST_DECODE) dec_q <= i_dec;
        if (stage == ST_EXECUTE) begin
            alu_q <= i_alu_result;
            taken_q <= i_branch_taken;
        end
    end

    // Load data is held by the bus master until the next transfer.
    assign o_rd_we = (stage == ST_WRITEBACK) && dec_q.writes_rd;
    assign o_rd = dec_q.rd;
    assign o_rd_wdata = dec_q.is_load ? i_bus_rdata :
                        dec_q.is_jump ? pc_plus4 : alu_q;
    assign o_pc = pc;

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00);

endmodule

/* verilog/rv32_core.sv */
`timescale 1ns/1ns

module rv32_core
    import rv32_isa_pkg::*, core_pkg::*;
#(
    parameter word_t P_RESET_PC = 32'h0000_0000
) (
    input  logic  i_clk,
    input  logic  i_rst,
    output logic  o_cyc,
    output logic  o_stb,
    output logic  o_we,
    output word_t o_addr,
    output word_t o_data,
    input  logic  i_ack,
    input  logic  i_stall,
    input  word_t i_data
);

    word_t    instr;
    decoded_t dec;
    word_t    alu_result;
    logic     branch_taken;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    pc;
    logic     req_valid;
    bus_req_t req;
    logic     bus_idle;
    logic     bus_done;
    word_t    bus_rdata;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_wdata;

    rv32_control #(.P_RESET_PC(P_RESET_PC)) control0 (
        .i_clk(i_clk), .i_rst(i_rst), .o_instr(instr), .i_dec(dec),
        .i_alu_result(alu_result), .i_branch_taken(branch_taken), .i_rs2_val(rs2_val),
        .o_pc(pc), .o_req_valid(req_valid), .o_req(req), .i_bus_idle(bus_idle),
        .i_bus_done(bus_done), .i_bus_rdata(bus_rdata),
        .o_rd_we(rd_we), .o_rd(rd), .o_rd_wdata(rd_wdata)
    );

    rv32_decoder decoder0 (.i_instr(instr), .o_dec(dec));

    rv32_regfile regfile0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_rs1(dec.rs1), .i_rs2(dec.rs2),
        .o_rs1_val(rs1_val), .o_rs2_val(rs2_val),
        .i_we(rd_we), .i_rd(rd), .i_wdata(rd_wdata)
    );

    rv32_alu alu0 (
        .i_dec(dec), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_pc(pc),
        .o_result(alu_result), .o_branch_taken(branch_taken)
    );

    wb_master wb0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_req_valid(req_valid), .i_req(req),
        .o_idle(bus_idle), .o_done(bus_done), .o_rdata(bus_rdata),
        .o_cyc(o_cyc), .o_stb(o_stb), .o_we(o_we), .o_addr(o_addr), .o_data(o_data),
        .i_ack(i_ack), .i_stall(i_stall), .i_data(i_data)
    );

endmodule

/* test/tb_rv32_core.sv */
`timescale 1ns/1ns

module tb_rv32_core
    import rv32_isa_pkg::*;
;

    localparam int    CLK_PERIOD = 40;
    localparam int    SEED = 32'h89e9;
    localparam int    MEM_WORDS = 512;
    localparam int    MAX_CASES = 64;
    localparam word_t RESET_PC = 32'h0000_0100;
    localparam word_t DATA_BASE = 32'h0000_0500;
    localparam word_t RES_BASE = 32'h0000_0700;
    localparam int    CYC_PER_INSTR = 30; // Two bus transfers with worst stall and ack delay.

    // Instruction classes for the reference model.
    localparam int CLS_OP = 0;
    localparam int CLS_IMM = 1;
    localparam int CLS_LUI = 2;
    localparam int CLS_AUIPC = 3;
    localparam int CLS_BRANCH = 4;
    localparam int CLS_JUMP = 5;

    logic  i_clk;
    logic  i_rst;
    logic  i_ack;
    logic  i_stall;
    word_t i_data;
    logic  o_cyc;
    logic  o_stb;
    logic  o_we;
    word_t o_addr;
    word_t o_data;

    word_t   mem [MEM_WORDS];
    word_t   expected [MAX_CASES];
    bit      seen [MAX_CASES];
    int      n_cases = 0;
    int      n_stores = 0;
    int      data_errors = 0;
    int      proto_errors = 0;
    int      data_idx = 0;
    word_t   bld_pc;
    bit      built = 0;
    bit      first_done = 0;
    longint  wd_limit;
    int      stall_run = 0;
    bit      pending = 0;
    int      ack_cnt = 0;
    word_t   addr_q;

    rv32_core #(.P_RESET_PC(RESET_PC)) dut0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .o_cyc(o_cyc), .o_stb(o_stb), .o_we(o_we), .o_addr(o_addr), .o_data(o_data),
        .i_ack(i_ack), .i_stall(i_stall), .i_data(i_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2);
        return {imm[11:5], rs2, 5'd0, F3_LW_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Expected stored word per the RV32I rules.
    function automatic word_t ref_exec(input int cls, input logic [2:0] f3,
                                       input logic [6:0] f7, input word_t a,
                                       input word_t b, input word_t imm, input word_t pc);
        logic taken;
        if (cls == CLS_LUI) return imm;
        if (cls == CLS_AUIPC) return pc + imm;
        if (cls == CLS_JUMP) return pc + 32'd4; // Link value.
        if (cls == CLS_BRANCH) begin
            case (f3)
                F3_BEQ:  taken = (a == b);
                F3_BNE:  taken = (a != b);
                F3_BLT:  taken = ($signed(a) < $signed(b));
                F3_BGE:  taken = ($signed(a) >= $signed(b));
                F3_BLTU: taken = (a < b);
                default: taken = (a >= b);
            endcase
            return taken ? 32'd1 : 32'd2; // Marker survives only when not skipped.
        end
        case (f3)
            F3_ADD:  return (cls == CLS_OP && f7 == F7_ALT) ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_SR:   return (f7 == F7_ALT) ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input word_t instr);
        mem[bld_pc[10:2]] = instr;
        bld_pc = bld_pc + 32'd4;
    endtask

    task automatic load_reg(input reg_idx_t rd, input word_t value);
        word_t addr;
        addr = DATA_BASE + word_t'(data_idx * 4);
        mem[addr[10:2]] = value;
        data_idx++;
        emit(enc_i(addr[11:0], 5'd0, F3_LW_SW, rd, OPC_LOAD));
    endtask

    task automatic store_result(input reg_idx_t rs, input word_t exp);
        word_t addr;
        addr = RES_BASE + word_t'(n_cases * 4); // Slot identifies the case.
        emit(enc_s(addr[11:0], rs));
        expected[n_cases] = exp;
        n_cases++;
    endtask

    task automatic add_rr(input logic [2:0] f3, input logic [6:0] f7);
        word_t a;
        word_t b;
        a = $urandom;
        b = $urandom;
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, ref_exec(CLS_OP, f3, f7, a, b, 32'd0, 32'd0));
    endtask

    task automatic add_ri(input logic [2:0] f3, input logic [11:0] imm);
        word_t a;
        a = $urandom;
        load_reg(5'd1, a);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
        store_result(5'd3, ref_exec(CLS_IMM, f3, imm[11:5], a,
                                    {{20{imm[11]}}, imm}, 32'd0, 32'd0));
    endtask

    task automatic add_branch(input logic [2:0] f3, input word_t a, input word_t b);
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, f3));
        emit(enc_i(12'd2, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM)); // Marker.
        store_result(5'd3, ref_exec(CLS_BRANCH, f3, 7'd0, a, b, 32'd0, 32'd0));
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        word_t p;
        logic [19:0] u;
        bld_pc = RESET_PC;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        for (int r = 0; r < 2; r++) begin
            for (int f = 0; f < 8; f++) begin
                add_rr(3'(f), 7'd0);
            end
            add_rr(F3_ADD, F7_ALT);
            add_rr(F3_SR, F7_ALT);
        end
        add_ri(F3_ADD, 12'($urandom));
        add_ri(F3_SLT, 12'($urandom));
        add_ri(F3_SLTU, 12'($urandom));
        add_ri(F3_XOR, 12'($urandom));
        add_ri(F3_OR, 12'($urandom));
        add_ri(F3_AND, 12'($urandom));
        add_ri(F3_SLL, {7'd0, 5'($urandom)});
        add_ri(F3_SR, {7'd0, 5'($urandom)});
        add_ri(F3_SR, {F7_ALT, 5'($urandom)});
        u = 20'($urandom);
        emit({u, 5'd3, OPC_LUI});
        store_result(5'd3, ref_exec(CLS_LUI, 3'd0, 7'd0, 32'd0, 32'd0, {u, 12'b0}, 32'd0));
        u = 20'($urandom);
        p = bld_pc;
        emit({u, 5'd3, OPC_AUIPC});
        store_result(5'd3, ref_exec(CLS_AUIPC, 3'd0, 7'd0, 32'd0, 32'd0, {u, 12'b0}, p));
        load_reg(5'd1, $urandom); // Write to x0 must be dropped.
        emit(enc_r(7'd0, 5'd1, 5'd1, F3_ADD, 5'd0));
        store_result(5'd0, 32'd0);
        a = $urandom;
        b = a ^ 32'h8000_0001;
        add_branch(F3_BEQ, a, a);
        add_branch(F3_BEQ, a, b);
        add_branch(F3_BNE, a, a);
        add_branch(F3_BNE, a, b);
        add_branch(F3_BLT, a, b);
        add_branch(F3_BLT, b, a);
        add_branch(F3_BGE, a, b);
        add_branch(F3_BGE, b, a);
        add_branch(F3_BLTU, a, b);
        add_branch(F3_BLTU, b, a);
        add_branch(F3_BGEU, a, b);
        add_branch(F3_BGEU, b, a);
        p = bld_pc;
        emit(enc_j(21'd12, 5'd3));
        emit(enc_i(12'd7, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
        emit(enc_i(12'd7, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
        store_result(5'd3, ref_exec(CLS_JUMP, 3'd0, 7'd0, 32'd0, 32'd0, 32'd0, p));
        p = bld_pc + 32'd4;
        load_reg(5'd1, p + 32'd4); // Odd sum, bit 0 is cleared.
        emit(enc_i(12'd5, 5'd1, 3'd0, 5'd3, OPC_JALR));
        emit(enc_i(12'd7, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
        store_result(5'd3, ref_exec(CLS_JUMP, 3'd0, 7'd0, 32'd0, 32'd0, 32'd0, p));
        emit(enc_j(21'd0, 5'd0)); // Park.
    endtask

    // Wishbone slave with random stall and ack delay.
    always @(posedge i_clk) begin
        bit stall_draw;
        stall_draw = ($urandom % 3 == 0) && (stall_run < 3);
        stall_run = stall_draw ? stall_run + 1 : 0;
        i_stall <= stall_draw;
        i_ack <= 1'b0;
        if (pending) begin
            if (ack_cnt == 0) begin
                i_ack <= 1'b1;
                i_data <= mem[addr_q[10:2]];
                pending = 0;
            end else begin
                ack_cnt--;
            end
        end
        if (!i_rst && o_cyc && o_stb && !i_stall) begin
            pending = 1;
            ack_cnt = $urandom % 4;
            addr_q = o_addr;
            if (o_we) mem[o_addr[10:2]] = o_data;
        end
    end

    always @(posedge i_clk) begin
        int idx;
        if (!i_rst && o_cyc && o_stb && !i_stall) begin
            if (!first_done) begin
                first_done = 1;
                if (o_we || o_addr !== RESET_PC) begin
                    proto_errors++;
                    $display("First transfer after reset is not a read at the reset PC, t=%0t",
                             $time);
                end
            end
            if (o_addr[1:0] !== 2'b00) begin
                proto_errors++;
                $display("Transfer address %h is not word-aligned at t=%0t", o_addr, $time);
            end
            if (o_we) begin
                idx = int'((o_addr - RES_BASE) >> 2);
                if (o_addr < RES_BASE || idx >= n_cases) begin
                    proto_errors++;
                    $display("Store to unexpected address %h at t=%0t", o_addr, $time);
                end else if (seen[idx]) begin
                    proto_errors++;
                    $display("Case %0d stored twice at t=%0t", idx, $time);
                end else begin
                    seen[idx] = 1;
                    n_stores++;
                    if (o_data !== expected[idx]) begin
                        data_errors++;
                        $display("Error: t=%0t o_data (case %0d) got %h expected %h",
                                 $time, idx, o_data, expected[idx]);
                    end
                end
            end
        end
    end

    initial begin
        wait (built);
        #(wd_limit);
        $display("Timeout after %0d ns, only %0d of %0d results stored",
                 wd_limit, n_stores, n_cases);
        $display("Regression failed");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_ack = 1'b0;
        i_stall = 1'b0;
        i_data = '0;
        void'($urandom(SEED));
        build_program();
        wd_limit = longint'((bld_pc - RESET_PC) / 4) * CYC_PER_INSTR * CLK_PERIOD
                   + 20 * CLK_PERIOD;
        built = 1;
        for (int i = 0; i < 8; i++) begin
            @(negedge i_clk);
            if (o_cyc !== 1'b0 || o_stb !== 1'b0 || o_we !== 1'b0) begin
                proto_errors++;
                $display("Bus control not low during reset at t=%0t", $time);
            end
        end
        @(posedge i_clk);
        i_rst <= 1'b0;
        wait (n_stores == n_cases);
        repeat (4) @(posedge i_clk);
        $display("Errors: %0d data, %0d protocol, %0d cases", data_errors, proto_errors,
                 n_cases);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/rv32_isa_pkg.sv
verilog/core_pkg.sv
verilog/rv32_decoder.sv
verilog/rv32_regfile.sv
verilog/rv32_alu.sv
verilog/wb_master.sv
verilog/rv32_control.sv
verilog/rv32_core.sv
test/tb_rv32_core.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_rv32_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
